// ==== tests/execGolden.txt ====
# columns in hex: op a b data carry zero overflow negative
# op: 0 add, 1 sub, 2 addc, 3 slt, 4 xor, 5 and, 6 andn, 7 rol, 8 sll, 9 ror, a srl
0 1234 4321 5555 0 0 0 0
0 ffff 0001 0000 1 1 0 0
2 0001 0001 0003 0 0 0 0
0 7fff 0001 8000 0 0 1 1
0 8000 8000 0000 1 1 1 0
4 f0f0 0ff0 ff00 1 0 0 1
2 0010 0020 0031 0 0 0 0
1 0005 0003 0002 1 0 0 0
1 0003 0005 fffe 0 0 0 1
1 8000 0001 7fff 1 0 1 0
1 7fff ffff 8000 0 0 1 1
1 1234 1234 0000 1 1 0 0
3 8000 0001 0001 1 0 1 0
3 7fff ffff 0000 0 1 1 0
3 fffe 0003 0001 1 0 0 0
3 0005 0005 0000 1 1 0 0
5 f0f0 3c3c 3030 1 0 0 0
6 f0f0 3c3c c0c0 1 0 0 1
4 aaaa aaaa 0000 1 1 0 0
6 ffff 00ff ff00 1 0 0 1
7 8001 0000 8001 1 0 0 1
7 8001 0001 0003 1 0 0 0
7 1234 0107 1a09 1 0 0 0
8 00ff 0008 ff00 1 0 0 1
8 8001 000f 8000 1 0 0 1
8 1234 0001 2468 1 0 0 0
9 0001 0001 8000 1 0 0 1
9 1234 ff08 3412 1 0 0 0
9 8001 000f 0003 1 0 0 0
a 8000 000f 0001 1 0 0 0
a ffff 0007 01ff 1 0 0 0
a 1234 0010 1234 1 0 0 0
a 0001 0001 0000 1 1 0 0
2 0001 0001 0003 0 0 0 0

// ==== sim.f ====
logic/aluPkg.sv
logic/execPkg.sv
logic/aluIf.sv
logic/cla4.sv
logic/shifter.sv
logic/alu.sv
logic/flagReg.sv
logic/execUnit.sv
logic/execTop.sv
tests/execTb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: obj_dir/execSim

obj_dir/execSim: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module execTb \
		-Mdir obj_dir -o execSim

run: obj_dir/execSim tests/execGolden.txt
	./obj_dir/execSim | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/execTb.sv ====
`timescale 1ns/1ps

module execTb;

    localparam logic [31:0] galoisTaps = 32'h80200003;

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    logic [3:0]  inOp;
    logic [15:0] inA;
    logic [15:0] inB;
    logic        outValid;
    logic        outReady;
    logic [15:0] outData;
    logic        outCarry;
    logic        outZero;
    logic        outOverflow;
    logic        outNegative;

    // one vector packs op, a, b, data and the carry, zero, overflow, negative flags.
    logic [55:0] vecs[$];
    int          expQ[$];
    logic [31:0] lfsrState = 32'h913c13b3;
    bit          loaded = 1'b0;
    int          nVec;
    int          resultCount;
    int          dataErrors;
    int          flagErrors;
    int          protocolErrors;

    execTop i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inReady     (inReady),
        .inOp        (inOp),
        .inA         (inA),
        .inB         (inB),
        .outValid    (outValid),
        .outReady    (outReady),
        .outData     (outData),
        .outCarry    (outCarry),
        .outZero     (outZero),
        .outOverflow (outOverflow),
        .outNegative (outNegative)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // random bits and checks
    // ----------------------------------------
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ galoisTaps;
        end
        return n;
    endfunction

    function automatic int drawBits(input int count);
        int val;
        val = 0;
        for (int k = 0; k < count; k++) begin
            val = (val << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
        return val;
    endfunction

    task automatic compareField(input string sigName, input logic [15:0] expVal,
                                input logic [15:0] actVal, input bit isFlag);
        assert (actVal === expVal) else begin
            $display("ERROR %0t %s expected %h got %h", $time, sigName, expVal, actVal);
            if (isFlag) begin
                flagErrors++;
            end else begin
                dataErrors++;
            end
        end
    endtask

    task automatic checkFlags(input logic [3:0] expFlags);
        compareField("outCarry", {15'd0, expFlags[3]}, {15'd0, outCarry}, 1'b1);
        compareField("outZero", {15'd0, expFlags[2]}, {15'd0, outZero}, 1'b1);
        compareField("outOverflow", {15'd0, expFlags[1]}, {15'd0, outOverflow}, 1'b1);
        compareField("outNegative", {15'd0, expFlags[0]}, {15'd0, outNegative}, 1'b1);
    endtask

    task automatic loadVectors();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] op, a, b, d, c, z, v, n;
        fd = $fopen("tests/execGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/execGolden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 op, a, b, d, c, z, v, n);
                    if (rc == 8) begin
                        vecs.push_back({op[3:0], a[15:0], b[15:0], d[15:0],
                                        c[0], z[0], v[0], n[0]});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // stimulus and result monitor
    // ----------------------------------------
    initial begin : stimulus
        int          nextIdx;
        int          gapLeft;
        int          idx;
        bit          sent;
        bit          holdActive;
        bit          expValid;
        bit          expReady;
        logic [19:0] held;
        logic [55:0] cur;
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = 4'd0;
        inA = 16'd0;
        inB = 16'd0;
        outReady = 1'b0;
        dataErrors = 0;
        flagErrors = 0;
        protocolErrors = 0;
        resultCount = 0;
        loadVectors();
        nVec = vecs.size();
        loaded = 1'b1;
        assert (nVec > 0) else begin
            $display("no vectors were read from tests/execGolden.txt");
            protocolErrors++;
        end
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        assert (!outValid) else begin
            $display("outValid is high right after reset");
            protocolErrors++;
        end
        checkFlags(4'b0000);

        nextIdx = 0;
        gapLeft = 0;
        sent = 1'b0;
        holdActive = 1'b0;
        held = 20'd0;
        while (resultCount < nVec) begin
            @(posedge clk);
            #1;
            if (sent) begin
                inValid = 1'b0;
                nextIdx++;
                gapLeft = drawBits(2);
                if (gapLeft < 2) begin
                    gapLeft = 0;
                end
            end
            outReady = (drawBits(2) != 0);
            if (!inValid && nextIdx < nVec) begin
                if (gapLeft == 0) begin
                    cur = vecs[nextIdx];
                    inOp = cur[55:52];
                    inA = cur[51:36];
                    inB = cur[35:20];
                    inValid = 1'b1;
                end else begin
                    gapLeft--;
                end
            end
            @(negedge clk);
            // a result that was refused last cycle must still be there unchanged.
            if (holdActive) begin
                assert (outValid) else begin
                    $display("outValid dropped before the result was taken");
                    protocolErrors++;
                end
                compareField("outData", held[19:4], outData, 1'b0);
                checkFlags(held[3:0]);
            end
            // the output register holds exactly the accepted results not yet taken.
            expValid = (expQ.size() > 0);
            expReady = !expValid || outReady;
            assert (outValid === expValid) else begin
                $display("ERROR %0t outValid expected %b got %b", $time, expValid, outValid);
                protocolErrors++;
            end
            assert (inReady === expReady) else begin
                $display("ERROR %0t inReady expected %b got %b", $time, expReady, inReady);
                protocolErrors++;
            end
            holdActive = outValid && !outReady;
            held = {outData, outCarry, outZero, outOverflow, outNegative};
            if (outValid && outReady) begin
                assert (expQ.size() > 0) else begin
                    $display("a result arrived with no request outstanding");
                    protocolErrors++;
                end
                if (expQ.size() > 0) begin
                    idx = expQ.pop_front();
                    cur = vecs[idx];
                    compareField("outData", cur[19:4], outData, 1'b0);
                    checkFlags(cur[3:0]);
                end
                resultCount++;
            end
            sent = inValid && inReady;
            if (sent) begin
                expQ.push_back(nextIdx);
            end
        end

        // nothing may follow the last result.
        repeat (3) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
            outReady = 1'b1;
            @(negedge clk);
            assert (!outValid) else begin
                $display("an extra result appeared after the last vector");
                protocolErrors++;
            end
        end

        $display("errors: data %0d, flags %0d, protocol %0d",
                 dataErrors, flagErrors, protocolErrors);
        if (dataErrors + flagErrors + protocolErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (nVec * 20 + 100) @(posedge clk);
        $display("watchdog expired, results stopped arriving after %0d of %0d",
                 resultCount, nVec);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== logic/execTop.sv ====
`timescale 1ns/1ps

module execTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         inValid,
    output logic                         inReady,
    input  logic [execPkg::opBits-1:0]   inOp,
    input  logic [aluPkg::dataWidth-1:0] inA,
    input  logic [aluPkg::dataWidth-1:0] inB,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [aluPkg::dataWidth-1:0] outData,
    output logic                         outCarry,
    output logic                         outZero,
    output logic                         outOverflow,
    output logic                         outNegative
);
    import execPkg::*;

    logic  storedCarry;
    logic  flagUpdate;
    logic  carryWrite;
    flagsT newFlags;
    flagsT flags;

    aluIf aluBus ();

    execUnit uExec (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inReady     (inReady),
        .inOp        (execOp'(inOp)),
        .inA         (inA),
        .inB         (inB),
        .outValid    (outValid),
        .outReady    (outReady),
        .outData     (outData),
        .storedCarry (storedCarry),
        .flagUpdate  (flagUpdate),
        .carryWrite  (carryWrite),
        .newFlags    (newFlags),
        .alu         (aluBus.ctrl)
    );

    flagReg uFlags (
        .clk         (clk),
        .rstN        (rstN),
        .update      (flagUpdate),
        .carryWrite  (carryWrite),
        .newFlags    (newFlags),
        .flags       (flags),
        .storedCarry (storedCarry)
    );

    alu uAlu (
        .bus (aluBus.core)
    );

    assign outCarry    = flags.carry;
    assign outZero     = flags.zero;
    assign outOverflow = flags.overflow;
    assign outNegative = flags.negative;

endmodule

// ==== logic/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         inValid,
    output logic                         inReady,
    input  execPkg::execOp               inOp,
    input  logic [aluPkg::dataWidth-1:0] inA,
    input  logic [aluPkg::dataWidth-1:0] inB,
    output logic                         outValid,
    input  logic                         outReady,
    output logic [aluPkg::dataWidth-1:0] outData,
    input  logic                         storedCarry,
    output logic                         flagUpdate,
    output logic                         carryWrite,
    output execPkg::flagsT               newFlags,
    aluIf.ctrl                           alu
);
    import aluPkg::*;
    import execPkg::*;

    logic                 isArith;
    logic                 isSlt;
    logic                 sltBit;
    logic                 accept;
    logic [dataWidth-1:0] resultNext;

    // ----------------------------------------
    // operation decode
    // ----------------------------------------
    // arithmetic runs in signed mode so overflow is the two's complement rule.
    always_comb begin
        alu.a          = inA;
        alu.b          = inB;
        alu.invA       = 1'b0;
        alu.invB       = 1'b0;
        alu.carryIn    = 1'b0;
        alu.signedMode = 1'b0;
        alu.func       = funcAdd;
        isArith        = 1'b0;
        case (inOp)
            opAdd: begin
                isArith = 1'b1;
            end
            opSub, opSlt: begin
                alu.invB    = 1'b1;
                alu.carryIn = 1'b1;
                isArith     = 1'b1;
            end
            opAddc: begin
                alu.carryIn = storedCarry;
                isArith     = 1'b1;
            end
            opXor:   alu.func = funcXor;
            opAnd:   alu.func = funcAnd;
            opAndn: begin
                alu.invB = 1'b1;
                alu.func = funcAnd;
            end
            opRol:   alu.func = funcRol;
            opSll:   alu.func = funcSll;
            opRor:   alu.func = funcRor;
            opSrl:   alu.func = funcSrl;
            default: alu.func = funcAdd;
        endcase
        alu.signedMode = isArith;
    end

    assign isSlt  = (inOp == opSlt);
    assign sltBit = alu.ltZero ^ alu.overflow;

    assign resultNext = isSlt ? {{(dataWidth-1){1'b0}}, sltBit} : alu.result;

    // flags describe the value that is delivered.
    assign newFlags.carry    = alu.carryOut;
    assign newFlags.zero     = isSlt ? ~sltBit : alu.zero;
    assign newFlags.overflow = isArith & alu.overflow;
    assign newFlags.negative = resultNext[dataWidth-1];
    assign carryWrite        = isArith;

    // ----------------------------------------
    // handshake and output register
    // ----------------------------------------
    assign inReady    = !outValid || outReady;
    assign accept     = inValid && inReady;
    assign flagUpdate = accept;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outData <= resultNext;
        end
    end

endmodule

// ==== logic/flagReg.sv ====
`timescale 1ns/1ps

module flagReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           update,
    input  logic           carryWrite,
    input  execPkg::flagsT newFlags,
    output execPkg::flagsT flags,
    output logic           storedCarry
);

    // zero, overflow and negative follow every accepted operation.
    // carry is kept across logic and shift operations.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags.carry    <= 1'b0;
            flags.zero     <= 1'b0;
            flags.overflow <= 1'b0;
            flags.negative <= 1'b0;
        end else if (update) begin
            flags.zero     <= newFlags.zero;
            flags.overflow <= newFlags.overflow;
            flags.negative <= newFlags.negative;
            if (carryWrite) begin
                flags.carry <= newFlags.carry;
            end
        end
    end

    assign storedCarry = flags.carry;

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    aluIf.core bus
);
    import aluPkg::*;

    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] shiftOut;
    logic [dataWidth-1:0] res;
    logic [4:0]           chain;

    assign opA = bus.invA ? ~bus.a : bus.a;
    assign opB = bus.invB ? ~bus.b : bus.b;

    // ----------------------------------------
    // adder from four chained slices
    // ----------------------------------------
    assign chain[0] = bus.carryIn;

    for (genvar s = 0; s < 4; s++) begin : gSlice
        cla4 uSlice (
            .a    (opA[4*s+3:4*s]),
            .b    (opB[4*s+3:4*s]),
            .cin  (chain[s]),
            .sum  (sum[4*s+3:4*s]),
            .cout (chain[s+1])
        );
    end

    assign bus.carryOut = chain[4];

    // the shift count is the low nibble of the second operand.
    shifter uShifter (
        .in   (opA),
        .cnt  (opB[3:0]),
        .mode (shiftMode'(bus.func[1:0])),
        .out  (shiftOut)
    );

    // ----------------------------------------
    // result select
    // ----------------------------------------
    always_comb begin
        res = sum;
        case (bus.func)
            funcRol, funcSll, funcRor, funcSrl: res = shiftOut;
            funcAdd, funcAddAlt:                res = sum;
            funcXor:                            res = opA ^ opB;
            funcAnd:                            res = opA & opB;
            default:                            res = sum;
        endcase
    end

    assign bus.result = res;
    assign bus.zero   = ~(|res);

    // signed overflow means both inputs share a sign that the sum does not.
    always_comb begin
        if (bus.signedMode) begin
            bus.overflow = (opA[msb] & opB[msb] & ~sum[msb])
                         | (~opA[msb] & ~opB[msb] & sum[msb]);
            bus.ltZero   = res[msb];
        end else begin
            bus.overflow = chain[4];
            bus.ltZero   = 1'b0;
        end
    end

endmodule

// ==== logic/shifter.sv ====
`timescale 1ns/1ps

module shifter (
    input  logic [15:0]     in,
    input  logic [3:0]      cnt,
    input  aluPkg::shiftMode mode,
    output logic [15:0]     out
);
    import aluPkg::*;

    logic [dataWidth-1:0] stageVal [0:4];

    // one stage moves the word by a fixed amount in the selected direction.
    function automatic logic [dataWidth-1:0] shiftStage(
        input logic [dataWidth-1:0] x,
        input int unsigned          amt,
        input shiftMode             m
    );
        logic [dataWidth-1:0] res;
        case (m)
            shiftRol: res = (x << amt) | (x >> (dataWidth - amt));
            shiftSll: res = x << amt;
            shiftRor: res = (x >> amt) | (x << (dataWidth - amt));
            default:  res = x >> amt;
        endcase
        return res;
    endfunction

    // ----------------------------------------
    // stages of 1, 2, 4 and 8 bits
    // ----------------------------------------
    always_comb begin
        stageVal[0] = in;
        for (int i = 0; i < 4; i++) begin
            if (cnt[i]) begin
                stageVal[i+1] = shiftStage(stageVal[i], 1 << i, mode);
            end else begin
                stageVal[i+1] = stageVal[i];
            end
        end
    end

    assign out = stageVal[4];

endmodule

// ==== logic/cla4.sv ====
`timescale 1ns/1ps

module cla4 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] sum,
    output logic       cout
);

    logic [3:0] gen;
    logic [3:0] prop;
    logic [3:0] carry;

    assign gen  = a & b;
    assign prop = a ^ b;

    // every carry is formed straight from generate and propagate, with no ripple.
    assign carry[0] = cin;
    assign carry[1] = gen[0] | (prop[0] & cin);
    assign carry[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & cin);
    assign carry[3] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & cin);
    assign cout     = gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1])
                    | (prop[3] & prop[2] & prop[1] & gen[0])
                    | (prop[3] & prop[2] & prop[1] & prop[0] & cin);

    assign sum = prop ^ carry;

endmodule

// ==== logic/aluIf.sv ====
`timescale 1ns/1ps

interface aluIf;
    import aluPkg::*;

    // controls and operands, driven by the execute unit.
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic                 invA;
    logic                 invB;
    logic                 carryIn;
    logic                 signedMode;
    aluFunc               func;

    // results, driven by the ALU.
    logic [dataWidth-1:0] result;
    logic                 carryOut;
    logic                 overflow;
    logic                 zero;
    logic                 ltZero;

    modport ctrl (
        output a, b, invA, invB, carryIn, signedMode, func,
        input  result, carryOut, overflow, zero, ltZero
    );

    modport core (
        input  a, b, invA, invB, carryIn, signedMode, func,
        output result, carryOut, overflow, zero, ltZero
    );

endinterface

// ==== logic/execPkg.sv ====
package execPkg;

    // width of the instruction operation code.
    localparam int opBits = 4;

    // ----------------------------------------
    // instruction operations
    // ----------------------------------------
    typedef enum logic [opBits-1:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAddc = 4'd2,
        opSlt  = 4'd3,
        opXor  = 4'd4,
        opAnd  = 4'd5,
        opAndn = 4'd6,
        opRol  = 4'd7,
        opSll  = 4'd8,
        opRor  = 4'd9,
        opSrl  = 4'd10
    } execOp;

    // ----------------------------------------
    // condition flags
    // ----------------------------------------
    // carry of a subtraction is the adder carry out, so it is set when no borrow occurs.
    typedef struct packed {
        logic carry;
        logic zero;
        logic overflow;
        logic negative;
    } flagsT;

endpackage

// ==== logic/aluPkg.sv ====
package aluPkg;

    // operand and result width of the datapath.
    localparam int dataWidth = 16;

    // ----------------------------------------
    // ALU function select
    // ----------------------------------------
    // codes 0 to 3 go to the shifter and use the low two bits as its mode.
    typedef enum logic [2:0] {
        funcRol    = 3'd0,
        funcSll    = 3'd1,
        funcRor    = 3'd2,
        funcSrl    = 3'd3,
        funcAdd    = 3'd4,
        funcAddAlt = 3'd5,
        funcXor    = 3'd6,
        funcAnd    = 3'd7
    } aluFunc;

    typedef enum logic [1:0] {
        shiftRol = 2'd0,
        shiftSll = 2'd1,
        shiftRor = 2'd2,
        shiftSrl = 2'd3
    } shiftMode;

endpackage
